// ==== common/disp_pkg.sv ====
// Display constants and glyph tables; segment bytes are active high, bit 7 = dp, bit 6..0 = a..g
package disp_pkg;

    localparam int DATA_W     = 32;
    localparam int ADDR_W     = 4;
    localparam int NUM_DIGITS = 8;
    localparam int DIGIT_W    = 3;
    localparam int SEG_W      = 8;

    localparam logic [ADDR_W-1:0] VALUE_OFS = 4'h0; // displayed value
    localparam logic [ADDR_W-1:0] CTRL_OFS  = 4'h4; // bit 0 run, bit 1 load

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    typedef enum logic [1:0] {
        MODE_BANNER = 2'd0,
        MODE_RUN    = 2'd1,
        MODE_LOAD   = 2'd2
    } disp_mode_t;

    localparam logic [SEG_W-1:0] HEX_GLYPHS [16] = '{
        8'h7e, 8'h30, 8'h6d, 8'h79, // 0..3
        8'h33, 8'h5b, 8'h5f, 8'h70, // 4..7
        8'h7f, 8'h7b, 8'h77, 8'h1f, // 8..b
        8'h4e, 8'h3d, 8'h4f, 8'h47  // c..f
    };

    // reads "StAndbY" from digit 7 down to digit 1, digit 0 blank
    localparam logic [SEG_W-1:0] BANNER_GLYPHS [NUM_DIGITS] = '{
        8'h00, 8'h3b, 8'h1f, 8'h3d, // blank Y b d
        8'h15, 8'h77, 8'h0f, 8'h5b  // n A t S
    };

    // scroll window of eight entries slides across this ring
    localparam logic [SEG_W-1:0] LOAD_GLYPHS [16] = '{
        8'h00, 8'h00, 8'h00, 8'h00,
        8'h00, 8'h00, 8'h00, 8'h0e, // blanks, L
        8'h1d, 8'h7d, 8'h3d, 8'h10, // o a d i
        8'h15, 8'hfb, 8'h80, 8'h80  // n g, two dots
    };

endpackage

// ==== common/seg_scan_if.sv ====
// One scan step per strobe from scan engine to glyph stage; no back-pressure, sink always accepts
`timescale 1ns/100ps

interface seg_scan_if;

    logic                             step;     // one-cycle strobe
    logic [disp_pkg::DIGIT_W-1:0]     digit;    // digit index of this step
    logic [3:0]                       nibble;   // hex nibble for that digit
    disp_pkg::disp_mode_t             mode;
    logic [3:0]                       load_ofs; // scroll position while loading

    modport src (
        output step,
        output digit,
        output nibble,
        output mode,
        output load_ofs
    );

    modport dst (
        input step,
        input digit,
        input nibble,
        input mode,
        input load_ofs
    );

endinterface

// ==== design/disp_regs.sv ====
// AXI4-Lite slave, one write and one read in flight, only word offsets 0 and 4 are mapped
`timescale 1ns/100ps

module disp_regs (
    input  logic                          CORE_CLK,
    input  logic                          arst_n_i,
    input  logic [disp_pkg::ADDR_W-1:0]   awaddr_i,
    input  logic                          awvalid_i,
    output logic                          awready_o,
    input  logic [disp_pkg::DATA_W-1:0]   wdata_i,
    input  logic [disp_pkg::DATA_W/8-1:0] wstrb_i,
    input  logic                          wvalid_i,
    output logic                          wready_o,
    output logic [1:0]                    bresp_o,
    output logic                          bvalid_o,
    input  logic                          bready_i,
    input  logic [disp_pkg::ADDR_W-1:0]   araddr_i,
    input  logic                          arvalid_i,
    output logic                          arready_o,
    output logic [disp_pkg::DATA_W-1:0]   rdata_o,
    output logic [1:0]                    rresp_o,
    output logic                          rvalid_o,
    input  logic                          rready_i,
    output logic [disp_pkg::DATA_W-1:0]   value_o,
    output disp_pkg::disp_mode_t          mode_o
);

    logic                        aw_w_rdy_q; // shared by both write channels
    logic                        wr_fire;
    logic                        rd_fire;
    logic                        wr_value_hit;
    logic                        wr_ctrl_hit;
    logic                        bvalid_q;
    logic                        rvalid_q;
    logic [1:0]                  bresp_q;
    logic [1:0]                  rresp_q;
    logic [disp_pkg::DATA_W-1:0] rdata_q;
    logic [disp_pkg::DATA_W-1:0] value_q;
    logic [1:0]                  ctrl_q;     // {load, run}

    assign wr_fire      = aw_w_rdy_q & awvalid_i & wvalid_i;
    assign rd_fire      = arvalid_i & ~rvalid_q;
    assign wr_value_hit = (awaddr_i == disp_pkg::VALUE_OFS);
    assign wr_ctrl_hit  = (awaddr_i == disp_pkg::CTRL_OFS);

    always_ff @(posedge CORE_CLK or negedge arst_n_i) begin
        if (!arst_n_i) begin
            aw_w_rdy_q <= 1'b0;
            bvalid_q   <= 1'b0;
            rvalid_q   <= 1'b0;
            value_q    <= '0;
            ctrl_q     <= '0;
        end else begin
            // single-cycle ready pulse, held off while a response waits
            aw_w_rdy_q <= awvalid_i & wvalid_i & ~bvalid_q & ~aw_w_rdy_q;

            if (wr_fire) begin
                bvalid_q <= 1'b1;
            end else if (bready_i) begin
                bvalid_q <= 1'b0;
            end

            if (rd_fire) begin
                rvalid_q <= 1'b1;
            end else if (rready_i) begin
                rvalid_q <= 1'b0;
            end

            if (wr_fire && wr_value_hit) begin
                for (int b = 0; b < disp_pkg::DATA_W / 8; b++) begin
                    if (wstrb_i[b]) begin
                        value_q[8*b +: 8] <= wdata_i[8*b +: 8];
                    end
                end
            end
            if (wr_fire && wr_ctrl_hit && wstrb_i[0]) begin
                ctrl_q <= wdata_i[1:0]; // upper bits not stored
            end
        end
    end

    // response payload
    always_ff @(posedge CORE_CLK or negedge arst_n_i) begin
        if (!arst_n_i) begin
            bresp_q <= '0;
            rresp_q <= '0;
            rdata_q <= '0;
        end else begin
            if (wr_fire) begin
                bresp_q <= (wr_value_hit || wr_ctrl_hit) ? disp_pkg::RESP_OKAY
                                                         : disp_pkg::RESP_SLVERR;
            end
            if (rd_fire) begin
                if (araddr_i == disp_pkg::VALUE_OFS) begin
                    rdata_q <= value_q;
                    rresp_q <= disp_pkg::RESP_OKAY;
                end else if (araddr_i == disp_pkg::CTRL_OFS) begin
                    rdata_q <= {{(disp_pkg::DATA_W - 2){1'b0}}, ctrl_q};
                    rresp_q <= disp_pkg::RESP_OKAY;
                end else begin
                    rdata_q <= '0;
                    rresp_q <= disp_pkg::RESP_SLVERR;
                end
            end
        end
    end

    // load outranks run
    always_comb begin
        if (ctrl_q[1]) begin
            mode_o = disp_pkg::MODE_LOAD;
        end else if (ctrl_q[0]) begin
            mode_o = disp_pkg::MODE_RUN;
        end else begin
            mode_o = disp_pkg::MODE_BANNER;
        end
    end

    assign awready_o = aw_w_rdy_q;
    assign wready_o  = aw_w_rdy_q;
    assign bvalid_o  = bvalid_q;
    assign bresp_o   = bresp_q;
    assign arready_o = ~rvalid_q;
    assign rvalid_o  = rvalid_q;
    assign rresp_o   = rresp_q;
    assign rdata_o   = rdata_q;
    assign value_o   = value_q;

endmodule

// ==== seven_seg/seg_scan.sv ====
// Scan engine; SCAN_DIV >= 1 and LOAD_STEP >= 1, value is latched once per sweep at digit 0
`timescale 1ns/100ps

module seg_scan #(
    parameter int SCAN_DIV  = 16000,
    parameter int LOAD_STEP = 512
) (
    input  logic                        CORE_CLK,
    input  logic                        arst_n_i,
    input  logic [disp_pkg::DATA_W-1:0] value_i,
    input  disp_pkg::disp_mode_t        mode_i,
    seg_scan_if.src                     scan
);

    localparam int DIV_W   = $clog2(SCAN_DIV + 1);
    localparam int LSTEP_W = $clog2(LOAD_STEP + 1);

    logic [DIV_W-1:0]             div_cnt_q;
    logic                         tick;
    logic [disp_pkg::DIGIT_W-1:0] sweep_cnt_q; // digit of the coming step
    logic                         step_q;
    logic [disp_pkg::DIGIT_W-1:0] digit_q;
    disp_pkg::disp_mode_t         mode_q;
    logic [3:0]                   nibble_q;
    logic [disp_pkg::DATA_W-1:0]  snap_q;
    logic [disp_pkg::DATA_W-1:0]  src_val;
    logic [LSTEP_W-1:0]           lstep_cnt_q;
    logic [3:0]                   load_ofs_q;

    assign tick    = (div_cnt_q == SCAN_DIV - 1);
    assign src_val = (sweep_cnt_q == '0) ? value_i : snap_q; // digit 0 sees the fresh value

    always_ff @(posedge CORE_CLK or negedge arst_n_i) begin
        if (!arst_n_i) begin
            div_cnt_q   <= '0;
            sweep_cnt_q <= '0;
            step_q      <= 1'b0;
            digit_q     <= '0;
            mode_q      <= disp_pkg::MODE_BANNER;
        end else begin
            step_q <= tick;
            if (tick) begin
                div_cnt_q   <= '0;
                digit_q     <= sweep_cnt_q;
                sweep_cnt_q <= sweep_cnt_q + 1'b1; // wraps after digit 7
                mode_q      <= mode_i;
            end else begin
                div_cnt_q <= div_cnt_q + 1'b1;
            end
        end
    end

    always_ff @(posedge CORE_CLK or negedge arst_n_i) begin
        if (!arst_n_i) begin
            nibble_q <= '0;
            snap_q   <= '0;
        end else if (tick) begin
            nibble_q <= src_val[4*sweep_cnt_q +: 4];
            if (sweep_cnt_q == '0) begin
                snap_q <= value_i;
            end
        end
    end

    // scroll position, parked at 0 outside load mode
    always_ff @(posedge CORE_CLK or negedge arst_n_i) begin
        if (!arst_n_i) begin
            lstep_cnt_q <= '0;
            load_ofs_q  <= '0;
        end else if (mode_i != disp_pkg::MODE_LOAD) begin
            lstep_cnt_q <= '0;
            load_ofs_q  <= '0;
        end else if (tick) begin
            if (lstep_cnt_q == LOAD_STEP - 1) begin
                lstep_cnt_q <= '0;
                load_ofs_q  <= load_ofs_q + 1'b1;
            end else begin
                lstep_cnt_q <= lstep_cnt_q + 1'b1;
            end
        end
    end

    assign scan.step     = step_q;
    assign scan.digit    = digit_q;
    assign scan.nibble   = nibble_q;
    assign scan.mode     = mode_q;
    assign scan.load_ofs = load_ofs_q;

endmodule

// ==== seven_seg/seg_glyph.sv ====
// Glyph stage; cathodes and anodes are active low and change together one cycle after step
`timescale 1ns/100ps

module seg_glyph (
    input  logic                           CORE_CLK,
    input  logic                           arst_n_i,
    seg_scan_if.dst                        scan,
    output logic [disp_pkg::SEG_W-1:0]      seg_o,
    output logic [disp_pkg::NUM_DIGITS-1:0] an_o
);

    logic [3:0]                      load_idx;
    logic [disp_pkg::SEG_W-1:0]      glyph;
    logic [disp_pkg::NUM_DIGITS-1:0] an_nxt;

    // leftmost digit shows the lowest ring entry of the window
    assign load_idx = scan.load_ofs + 4'd7 - {1'b0, scan.digit};

    always_comb begin
        case (scan.mode)
            disp_pkg::MODE_RUN: begin
                glyph = disp_pkg::HEX_GLYPHS[scan.nibble];
            end
            disp_pkg::MODE_BANNER: begin
                glyph = disp_pkg::BANNER_GLYPHS[scan.digit];
            end
            disp_pkg::MODE_LOAD: begin
                glyph = disp_pkg::LOAD_GLYPHS[load_idx];
            end
            default: begin
                glyph = '0; // unused encoding, blank
            end
        endcase
    end

    always_comb begin
        an_nxt             = '1;
        an_nxt[scan.digit] = 1'b0; // one-cold
    end

    always_ff @(posedge CORE_CLK or negedge arst_n_i) begin
        if (!arst_n_i) begin
            seg_o <= '1; // blank
            an_o  <= '1;
        end else if (scan.step) begin
            seg_o <= ~glyph;
            an_o  <= an_nxt;
        end
    end

endmodule

// ==== design/status_display_top.sv ====
// Status display top; AXI4-Lite slave with 4-bit word offsets, drives an 8-digit common-anode display
`timescale 1ns/100ps

module status_display_top #(
    parameter int SCAN_DIV  = 16000, // clock cycles per digit
    parameter int LOAD_STEP = 512    // scan steps per scroll position
) (
    input  logic                            CORE_CLK,
    input  logic                            arst_n_i,
    input  logic [disp_pkg::ADDR_W-1:0]     awaddr_i,
    input  logic                            awvalid_i,
    output logic                            awready_o,
    input  logic [disp_pkg::DATA_W-1:0]     wdata_i,
    input  logic [disp_pkg::DATA_W/8-1:0]   wstrb_i,
    input  logic                            wvalid_i,
    output logic                            wready_o,
    output logic [1:0]                      bresp_o,
    output logic                            bvalid_o,
    input  logic                            bready_i,
    input  logic [disp_pkg::ADDR_W-1:0]     araddr_i,
    input  logic                            arvalid_i,
    output logic                            arready_o,
    output logic [disp_pkg::DATA_W-1:0]     rdata_o,
    output logic [1:0]                      rresp_o,
    output logic                            rvalid_o,
    input  logic                            rready_i,
    output logic [disp_pkg::SEG_W-1:0]      seg_o,
    output logic [disp_pkg::NUM_DIGITS-1:0] an_o
);

    logic [disp_pkg::DATA_W-1:0] disp_value;
    disp_pkg::disp_mode_t        disp_mode;

    seg_scan_if scan_if ();

    disp_regs disp_regs_i (
        .CORE_CLK  (CORE_CLK),
        .arst_n_i  (arst_n_i),
        .awaddr_i  (awaddr_i),
        .awvalid_i (awvalid_i),
        .awready_o (awready_o),
        .wdata_i   (wdata_i),
        .wstrb_i   (wstrb_i),
        .wvalid_i  (wvalid_i),
        .wready_o  (wready_o),
        .bresp_o   (bresp_o),
        .bvalid_o  (bvalid_o),
        .bready_i  (bready_i),
        .araddr_i  (araddr_i),
        .arvalid_i (arvalid_i),
        .arready_o (arready_o),
        .rdata_o   (rdata_o),
        .rresp_o   (rresp_o),
        .rvalid_o  (rvalid_o),
        .rready_i  (rready_i),
        .value_o   (disp_value),
        .mode_o    (disp_mode)
    );

    seg_scan #(
        .SCAN_DIV  (SCAN_DIV),
        .LOAD_STEP (LOAD_STEP)
    ) seg_scan_i (
        .CORE_CLK (CORE_CLK),
        .arst_n_i (arst_n_i),
        .value_i  (disp_value),
        .mode_i   (disp_mode),
        .scan     (scan_if.src)
    );

    seg_glyph seg_glyph_i (
        .CORE_CLK (CORE_CLK),
        .arst_n_i (arst_n_i),
        .scan     (scan_if.dst),
        .seg_o    (seg_o),
        .an_o     (an_o)
    );

endmodule

// ==== test/tb_status_display.sv ====
// Directed testbench; SCAN_DIV 4 and LOAD_STEP 64 keep sweeps short, one AXI transfer at a time
`timescale 1ns/100ps

module tb_status_display;

    localparam int SCAN_DIV    = 4;
    localparam int LOAD_STEP   = 64;
    localparam int NUM_TESTS   = 6;
    localparam int RESP_LIMIT  = 20;               // cycles allowed for an AXI response
    localparam int DIGIT_LIMIT = 16 * SCAN_DIV + 8; // two sweeps plus pipeline
    localparam int WATCHDOG_NS = 2 * NUM_TESTS * 8 * SCAN_DIV * 20
                               + 2 * LOAD_STEP * SCAN_DIV * 20 + 20000;

    localparam logic [7:0] HEX_TAB [16] = '{
        8'h7e, 8'h30, 8'h6d, 8'h79, 8'h33, 8'h5b, 8'h5f, 8'h70,
        8'h7f, 8'h7b, 8'h77, 8'h1f, 8'h4e, 8'h3d, 8'h4f, 8'h47
    };
    localparam logic [7:0] BANNER_TAB [8] = '{
        8'h00, 8'h3b, 8'h1f, 8'h3d, 8'h15, 8'h77, 8'h0f, 8'h5b
    };
    localparam logic [7:0] LOAD_TAB [16] = '{
        8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h0e,
        8'h1d, 8'h7d, 8'h3d, 8'h10, 8'h15, 8'hfb, 8'h80, 8'h80
    };

    logic        CORE_CLK;
    logic        arst_n_i;
    logic [3:0]  awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [3:0]  araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;
    logic [7:0]  seg;
    logic [7:0]  an;

    logic [7:0]  exp_seg [8]; // expected cathodes of one sweep
    int          err_cnt;
    int          chk_cnt;
    logic [31:0] rng_state;

    status_display_top #(
        .SCAN_DIV  (SCAN_DIV),
        .LOAD_STEP (LOAD_STEP)
    ) status_display_top_i (
        .CORE_CLK  (CORE_CLK),
        .arst_n_i  (arst_n_i),
        .awaddr_i  (awaddr),
        .awvalid_i (awvalid),
        .awready_o (awready),
        .wdata_i   (wdata),
        .wstrb_i   (wstrb),
        .wvalid_i  (wvalid),
        .wready_o  (wready),
        .bresp_o   (bresp),
        .bvalid_o  (bvalid),
        .bready_i  (bready),
        .araddr_i  (araddr),
        .arvalid_i (arvalid),
        .arready_o (arready),
        .rdata_o   (rdata),
        .rresp_o   (rresp),
        .rvalid_o  (rvalid),
        .rready_i  (rready),
        .seg_o     (seg),
        .an_o      (an)
    );

    initial begin
        CORE_CLK = 1'b0;
        forever #10 CORE_CLK = ~CORE_CLK;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        chk_cnt++;
        assert (got === exp) else begin
            err_cnt++;
            $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic report(input string what);
        err_cnt++;
        $display("Error at %0t ns: %s", $time, what);
    endtask

    task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, output logic [1:0] resp);
        int n;
        n = 0;
        @(negedge CORE_CLK);
        awaddr  = addr;
        wdata   = data;
        wstrb   = strb;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        @(negedge CORE_CLK);
        while (!(awready && wready) && n < RESP_LIMIT) begin
            @(negedge CORE_CLK);
            n++;
        end
        @(negedge CORE_CLK); // handshake taken on the edge before
        awvalid = 1'b0;
        wvalid  = 1'b0;
        while (!bvalid && n < RESP_LIMIT) begin
            @(negedge CORE_CLK);
            n++;
        end
        chk_cnt++;
        assert (n < RESP_LIMIT) else report($sformatf("no write response at offset %h", addr));
        resp = bresp;
    endtask

    task automatic axi_read(input logic [3:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        int n;
        n = 0;
        @(negedge CORE_CLK);
        araddr  = addr;
        arvalid = 1'b1;
        @(negedge CORE_CLK);
        while (!rvalid && n < RESP_LIMIT) begin
            @(negedge CORE_CLK);
            n++;
        end
        arvalid = 1'b0;
        chk_cnt++;
        assert (n < RESP_LIMIT) else report($sformatf("no read response at offset %h", addr));
        data = rdata;
        resp = rresp;
    endtask

    task automatic find_digit(input int k);
        logic [7:0] target;
        int         n;
        target = ~(8'h01 << k); // one-cold anode
        n      = 0;
        while (an !== target && n < DIGIT_LIMIT) begin
            @(negedge CORE_CLK);
            n++;
        end
        chk_cnt++;
        assert (n < DIGIT_LIMIT) else report($sformatf("digit %0d never lit", k));
    endtask

    task automatic wait_digit(input int k);
        find_digit(k);
        compare($sformatf("seg_o digit %0d", k), seg, exp_seg[k]);
    endtask

    // skip the current sweep so the checked one starts after any register change
    task automatic check_sweep();
        find_digit(0);
        find_digit(7);
        for (int k = 0; k < 8; k++) begin
            wait_digit(k);
        end
    endtask

    task automatic test_reset_banner();
        compare("an_o", an, 8'hff);
        compare("seg_o", seg, 8'hff);
        for (int k = 0; k < 8; k++) begin
            exp_seg[k] = ~BANNER_TAB[k];
        end
        check_sweep();
    endtask

    task automatic test_registers();
        logic [31:0] v;
        logic [31:0] ctl;
        logic [31:0] part;
        logic [31:0] got;
        logic [1:0]  resp;
        rng_state = xorshift32(rng_state);
        v         = rng_state;
        axi_write(disp_pkg::VALUE_OFS, v, 4'hf, resp);
        compare("bresp", resp, disp_pkg::RESP_OKAY);
        axi_read(disp_pkg::VALUE_OFS, got, resp);
        compare("rdata value", got, v);
        compare("rresp", resp, disp_pkg::RESP_OKAY);
        rng_state = xorshift32(rng_state);
        ctl       = rng_state;
        axi_write(disp_pkg::CTRL_OFS, ctl, 4'hf, resp);
        compare("bresp", resp, disp_pkg::RESP_OKAY);
        axi_read(disp_pkg::CTRL_OFS, got, resp);
        compare("rdata ctrl", got, ctl & 32'h3); // only run and load stored
        compare("rresp", resp, disp_pkg::RESP_OKAY);
        rng_state = xorshift32(rng_state);
        part      = rng_state;
        axi_write(disp_pkg::VALUE_OFS, part, 4'b0101, resp);
        axi_read(disp_pkg::VALUE_OFS, got, resp);
        compare("rdata strobed", got, {v[31:24], part[23:16], v[15:8], part[7:0]});
    endtask

    task automatic test_unmapped();
        logic [31:0] v;
        logic [31:0] got;
        logic [1:0]  resp;
        rng_state = xorshift32(rng_state);
        v         = rng_state;
        axi_write(disp_pkg::VALUE_OFS, v, 4'hf, resp);
        axi_write(disp_pkg::CTRL_OFS, v, 4'hf, resp);
        axi_write(4'h8, ~v, 4'hf, resp); // differs from both registers if it lands
        compare("bresp unmapped", resp, disp_pkg::RESP_SLVERR);
        axi_read(4'h8, got, resp);
        compare("rresp unmapped", resp, disp_pkg::RESP_SLVERR);
        compare("rdata unmapped", got, 32'h0);
        axi_read(disp_pkg::VALUE_OFS, got, resp);
        compare("rdata value", got, v);
        axi_read(disp_pkg::CTRL_OFS, got, resp);
        compare("rdata ctrl", got, v & 32'h3);
    endtask

    task automatic test_run_mode();
        logic [31:0] v;
        logic [1:0]  resp;
        rng_state = xorshift32(rng_state);
        v         = rng_state;
        axi_write(disp_pkg::CTRL_OFS, 32'h1, 4'hf, resp);
        axi_write(disp_pkg::VALUE_OFS, v, 4'hf, resp);
        for (int k = 0; k < 8; k++) begin
            exp_seg[k] = ~HEX_TAB[v[4*k +: 4]];
        end
        check_sweep();
    endtask

    task automatic test_load_mode();
        logic [1:0] resp;
        axi_write(disp_pkg::CTRL_OFS, 32'h3, 4'hf, resp); // load beats run
        for (int k = 0; k < 8; k++) begin
            exp_seg[k] = ~LOAD_TAB[(7 - k) % 16];
        end
        check_sweep();
        repeat (LOAD_STEP * SCAN_DIV) @(negedge CORE_CLK); // one scroll position
        for (int k = 0; k < 8; k++) begin
            exp_seg[k] = ~LOAD_TAB[(8 - k) % 16];
        end
        check_sweep();
    endtask

    task automatic test_backpressure();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] got;
        logic [1:0]  resp;
        int          n;
        rng_state = xorshift32(rng_state);
        a         = rng_state;
        rng_state = xorshift32(rng_state);
        b         = rng_state;
        n         = 0;
        @(negedge CORE_CLK);
        bready  = 1'b0;
        rready  = 1'b0;
        awaddr  = disp_pkg::VALUE_OFS;
        wdata   = a;
        wstrb   = 4'hf;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        @(negedge CORE_CLK);
        while (!awready && n < RESP_LIMIT) begin
            @(negedge CORE_CLK);
            n++;
        end
        @(negedge CORE_CLK);
        wdata   = b; // second write stays offered
        araddr  = disp_pkg::VALUE_OFS;
        arvalid = 1'b1;
        @(negedge CORE_CLK);
        arvalid = 1'b0;
        repeat (5) begin
            compare("bvalid_o", bvalid, 1'b1);
            compare("awready_o", awready, 1'b0);
            compare("wready_o", wready, 1'b0);
            compare("rvalid_o", rvalid, 1'b1);
            compare("arready_o", arready, 1'b0);
            @(negedge CORE_CLK);
        end
        compare("rdata held", rdata, a);
        bready = 1'b1;
        rready = 1'b1;
        n      = 0;
        while (!awready && n < RESP_LIMIT) begin
            @(negedge CORE_CLK);
            n++;
        end
        @(negedge CORE_CLK);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        while (!bvalid && n < RESP_LIMIT) begin
            @(negedge CORE_CLK);
            n++;
        end
        chk_cnt++;
        assert (n < RESP_LIMIT) else report("second write was never accepted");
        compare("bresp", bresp, disp_pkg::RESP_OKAY);
        axi_read(disp_pkg::VALUE_OFS, got, resp);
        compare("rdata value", got, b);
    endtask

    initial begin
        #(WATCHDOG_NS);
        report("watchdog expired before the tests finished");
        $display("%0d checks, %0d errors", chk_cnt, err_cnt);
        $display("Checks failed");
        $finish;
    end

    initial begin
        err_cnt   = 0;
        chk_cnt   = 0;
        rng_state = 32'hd48da4d7;
        arst_n_i  = 1'b0;
        awaddr    = '0;
        awvalid   = 1'b0;
        wdata     = '0;
        wstrb     = '0;
        wvalid    = 1'b0;
        bready    = 1'b1;
        araddr    = '0;
        arvalid   = 1'b0;
        rready    = 1'b1;
        repeat (3) @(posedge CORE_CLK);
        @(negedge CORE_CLK);
        arst_n_i = 1'b1;
        test_reset_banner();
        test_registers();
        test_unmapped();
        test_run_mode();
        test_load_mode();
        test_backpressure();
        $display("%0d checks, %0d errors", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== status_display.f ====
common/disp_pkg.sv
common/seg_scan_if.sv
design/disp_regs.sv
seven_seg/seg_scan.sv
seven_seg/seg_glyph.sv
design/status_display_top.sv
test/tb_status_display.sv
